// File: all.f
verilog/fetch_pkg.sv
verilog/ibus_pkg.sv
verilog/pc_select.sv
verilog/fetch_fsm.sv
verilog/fetch_watchdog.sv
verilog/prefetch_buffer.sv
verilog/if_stage.sv
tb/if_checker.sv
tb/tb_if_stage.sv

// File: tb/if_checker.sv
/*
  Fetch stage checker. Watches the IF/ID outputs, compares each word that
  decode takes with the expected address stream and keeps the row counts.
*/
`timescale 1ns/1ps
`default_nettype none

module if_checker #(
  parameter logic [31:0] DATA_KEY = 32'h5a5a_0000
) (
  input  wire         clk,
  input  wire         instr_valid_id_i,
  input  wire  [31:0] instr_rdata_id_i,
  input  wire         is_fetch_failed_i,
  input  wire  [31:0] branch_target_i,
  input  wire         if_busy_i,
  input  wire         perf_imiss_i,
  input  wire         instr_rvalid_i,
  input  wire         id_ready_i,
  input  wire         halt_if_i,
  input  wire         row_start_i,
  input  wire         row_end_i,
  input  wire         row_fail_i,
  input  wire         row_timeout_i,
  input  wire  [7:0]  row_idx_i,
  input  wire  [31:0] row_addr_i,
  output logic [7:0]  words_o,
  output logic        fail_seen_o,
  output int unsigned rows_o,
  output int unsigned bad_rows_o,
  output int unsigned checks_o
);

  logic [31:0] exp_addr;
  logic [31:0] start_addr;
  logic        active;
  int unsigned row_errs;
  // IF/ID state one sample back, for the hold check
  logic        prev_valid;
  logic        prev_taken;
  logic [31:0] prev_rdata;
  logic        taken;

  initial begin
    words_o     = '0;
    fail_seen_o = 1'b0;
    rows_o      = 0;
    bad_rows_o  = 0;
    checks_o    = 0;
    active      = 1'b0;
    row_errs    = 0;
    prev_valid  = 1'b0;
    prev_taken  = 1'b0;
    prev_rdata  = '0;
    exp_addr    = '0;
    start_addr  = '0;
  end

  // sampled mid-cycle, all inputs settled since the last rising edge
  always @(negedge clk) begin
    // decode takes the held word this cycle
    taken = instr_valid_id_i & id_ready_i & ~halt_if_i & ~row_start_i;
    if (row_start_i) begin
      active      = 1'b1;
      exp_addr    = row_addr_i;
      start_addr  = row_addr_i;
      row_errs    = 0;
      words_o     <= '0;
      fail_seen_o <= 1'b0;
      if (branch_target_i !== row_addr_i) begin
        $display("Error: row %0d branch_target_o expected %h got %h",
                 row_idx_i, row_addr_i, branch_target_i);
        row_errs++;
      end
      // a redirect always restarts the stream, so it counts as a miss
      if (perf_imiss_i !== 1'b1) begin
        $display("Error: row %0d perf_imiss_o expected %h got %h",
                 row_idx_i, 1'b1, perf_imiss_i);
        row_errs++;
      end
    end else if (row_end_i && active) begin
      active = 1'b0;
      rows_o++;
      if (row_timeout_i) begin
        if (row_fail_i) begin
          $display("row %0d: timed out waiting for is_fetch_failed_o", row_idx_i);
        end else begin
          $display("row %0d: timed out after %0d words", row_idx_i, words_o);
        end
        row_errs++;
      end
      if (row_errs != 0) begin
        $display("row %0d: %0d errors", row_idx_i, row_errs);
        bad_rows_o++;
      end else if (row_fail_i) begin
        $display("row %0d: ok, fetch failure flagged", row_idx_i);
      end else begin
        $display("row %0d: ok, %0d words from %h", row_idx_i, words_o, start_addr);
      end
    end else if (active) begin
      // stalled decode, IF/ID must not move
      if (!row_fail_i && prev_valid && !prev_taken) begin
        if (instr_valid_id_i !== 1'b1) begin
          $display("Error: row %0d instr_valid_id_o expected %h got %h",
                   row_idx_i, 1'b1, instr_valid_id_i);
          row_errs++;
        end else if (instr_rdata_id_i !== prev_rdata) begin
          $display("Error: row %0d instr_rdata_id_o under stall expected %h got %h",
                   row_idx_i, prev_rdata, instr_rdata_id_i);
          row_errs++;
        end
      end
      if (taken) begin
        checks_o++;
        if (instr_rdata_id_i !== (exp_addr ^ DATA_KEY)) begin
          $display("Error: row %0d instr_rdata_id_o expected %h got %h",
                   row_idx_i, exp_addr ^ DATA_KEY, instr_rdata_id_i);
          row_errs++;
        end
        exp_addr = exp_addr + 32'd4;
        words_o <= words_o + 8'd1;
      end
      if (row_fail_i && is_fetch_failed_i) begin
        fail_seen_o <= 1'b1;
      end
    end
    // an answer on the bus means a request is still outstanding
    if (active && instr_rvalid_i && if_busy_i !== 1'b1) begin
      $display("Error: row %0d if_busy_o expected %h got %h",
               row_idx_i, 1'b1, if_busy_i);
      row_errs++;
    end
    // a redirect drops the old word, no hold expected after it
    prev_valid = instr_valid_id_i & ~row_start_i;
    prev_taken = taken;
    prev_rdata = instr_rdata_id_i;
  end

endmodule

`default_nettype wire

// File: tb/tb_if_stage.sv
/*
  Testbench for the instruction fetch stage. Bus memory model with random
  grant delay, table of fetch redirects and a loop that applies each row.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_if_stage
  import fetch_pkg::*;
();

  localparam logic [31:0] DM_HALT       = 32'h1a11_0800;
  localparam logic [31:0] DATA_KEY      = 32'h5a5a_0000;
  localparam int          MAX_ROWS      = 16;
  localparam int          WAIT_PER_WORD = 200;

  logic        clk;
  logic        rst_n;
  pc_mux_e     pc_mux;
  exc_pc_mux_e exc_mux;
  trap_mux_e   trap_mux;
  logic [4:0]  exc_vec;
  logic [23:0] m_base;
  logic [23:0] mx_base;
  logic [23:0] u_base;
  logic [30:0] boot_addr;
  logic [31:0] jump_id;
  logic [31:0] jump_ex;
  logic [31:0] mepc;
  logic [31:0] depc;
  logic [31:0] pc;
  logic        instr_req;
  logic [31:0] instr_addr;
  wire         instr_gnt;
  logic        instr_rvalid;
  logic [31:0] instr_rdata;
  logic        instr_err;
  logic        req;
  logic        pc_set;
  logic        halt_if;
  logic        id_ready;
  logic        clear_valid;
  logic        instr_valid_id;
  logic [31:0] instr_rdata_id;
  logic        fetch_failed;
  logic [31:0] branch_target;
  logic        if_busy;
  logic        perf_imiss;
  // bus model state
  logic [1:0]  gnt_wait;
  logic        withhold_gnt;
  // handshake with the checker
  logic        row_start;
  logic        row_end;
  logic        row_fail;
  logic        row_timeout;
  logic [7:0]  row_idx;
  logic [31:0] row_addr;
  logic [7:0]  words_taken;
  logic        fail_seen;
  int unsigned rows_run;
  int unsigned rows_bad;
  int unsigned words_checked;

  // ------------------------------------------------------------------------
  // stimulus table, kind 0 normal, 1 protection error, 2 grant withheld
  // ------------------------------------------------------------------------
  pc_mux_e     tbl_mux   [MAX_ROWS];
  exc_pc_mux_e tbl_exc   [MAX_ROWS];
  trap_mux_e   tbl_trap  [MAX_ROWS];
  logic [4:0]  tbl_vec   [MAX_ROWS];
  logic [31:0] tbl_op    [MAX_ROWS];
  logic [7:0]  tbl_n     [MAX_ROWS];
  logic        tbl_stall [MAX_ROWS];
  logic [1:0]  tbl_kind  [MAX_ROWS];
  logic [31:0] tbl_addr  [MAX_ROWS];
  int unsigned tbl_len;

  always #20 clk = ~clk;

  if_stage #(
    .DM_HALT_ADDR (DM_HALT),
    .FIFO_DEPTH   (2),
    .GNT_TIMEOUT  (8)
  ) i_if_stage (
    .clk                 (clk),
    .rst_n               (rst_n),
    .pc_mux_i            (pc_mux),
    .exc_pc_mux_i        (exc_mux),
    .trap_addr_mux_i     (trap_mux),
    .exc_vec_pc_mux_i    (exc_vec),
    .m_trap_base_addr_i  (m_base),
    .m_trap_base_addrx_i (mx_base),
    .u_trap_base_addr_i  (u_base),
    .boot_addr_i         (boot_addr),
    .jump_target_id_i    (jump_id),
    .jump_target_ex_i    (jump_ex),
    .mepc_i              (mepc),
    .depc_i              (depc),
    .pc_i                (pc),
    .instr_req_o         (instr_req),
    .instr_addr_o        (instr_addr),
    .instr_gnt_i         (instr_gnt),
    .instr_rvalid_i      (instr_rvalid),
    .instr_rdata_i       (instr_rdata),
    .instr_err_pmp_i     (instr_err),
    .req_i               (req),
    .pc_set_i            (pc_set),
    .halt_if_i           (halt_if),
    .id_ready_i          (id_ready),
    .clear_instr_valid_i (clear_valid),
    .instr_valid_id_o    (instr_valid_id),
    .instr_rdata_id_o    (instr_rdata_id),
    .is_fetch_failed_o   (fetch_failed),
    .branch_target_o     (branch_target),
    .if_busy_o           (if_busy),
    .perf_imiss_o        (perf_imiss)
  );

  if_checker #(.DATA_KEY(DATA_KEY)) i_if_checker (
    .clk               (clk),
    .instr_valid_id_i  (instr_valid_id),
    .instr_rdata_id_i  (instr_rdata_id),
    .is_fetch_failed_i (fetch_failed),
    .branch_target_i   (branch_target),
    .if_busy_i         (if_busy),
    .perf_imiss_i      (perf_imiss),
    .instr_rvalid_i    (instr_rvalid),
    .id_ready_i        (id_ready),
    .halt_if_i         (halt_if),
    .row_start_i       (row_start),
    .row_end_i         (row_end),
    .row_fail_i        (row_fail),
    .row_timeout_i     (row_timeout),
    .row_idx_i         (row_idx),
    .row_addr_i        (row_addr),
    .words_o           (words_taken),
    .fail_seen_o       (fail_seen),
    .rows_o            (rows_run),
    .bad_rows_o        (rows_bad),
    .checks_o          (words_checked)
  );

  // ------------------------------------------------------------------------
  // bus model, grant 0 to 2 cycles after the last one, rvalid one cycle later
  // ------------------------------------------------------------------------
  assign instr_gnt = instr_req & (gnt_wait == 2'd0) & ~withhold_gnt;

  always @(posedge clk) begin
    instr_rvalid <= 1'b0;
    instr_err    <= 1'b0;
    if (instr_req && instr_gnt) begin
      instr_rvalid <= 1'b1;
      instr_rdata  <= instr_addr ^ DATA_KEY;
      // protected window 0x0000_f000 to 0x0000_f0ff
      instr_err    <= (instr_addr[31:8] == 24'h0000f0);
      gnt_wait     <= 2'($urandom % 3);
    end else if (gnt_wait != 2'd0) begin
      gnt_wait <= gnt_wait - 2'd1;
    end
  end

  // start address of a row, from the trap base and vector rules
  function automatic logic [31:0] calc_start(input pc_mux_e mux, input exc_pc_mux_e exc,
                                             input trap_mux_e trap, input logic [4:0] vec,
                                             input logic [31:0] op);
    logic [23:0] base;
    logic [31:0] exc_target;
    logic [31:0] addr;
    case (trap)
      TRAP_USER:     base = op[31:8] + 24'd2;
      TRAP_MACHINEX: base = op[31:8] + 24'd1;
      default:       base = op[31:8];
    endcase
    case (exc)
      EXC_PC_IRQ: exc_target = {base, 1'b0, vec, 2'b00};
      EXC_PC_DBD: exc_target = DM_HALT;
      default:    exc_target = {base, 8'h00};
    endcase
    case (mux)
      PC_BOOT:      addr = op + 32'h500;
      PC_JUMP:      addr = op;
      PC_BRANCH:    addr = op + 32'h100;
      PC_MRET:      addr = op + 32'h200;
      PC_DRET:      addr = op + 32'h300;
      // word after the fence
      PC_FENCEI:    addr = op + 32'h400 + 32'd4;
      PC_EXCEPTION: addr = exc_target;
      default:      addr = 32'h0;
    endcase
    return {addr[31:1], 1'b0};
  endfunction

  task automatic add_row(input pc_mux_e mux, input exc_pc_mux_e exc, input trap_mux_e trap,
                         input logic [4:0] vec, input logic [31:0] op, input logic [7:0] n,
                         input logic stall, input logic [1:0] kind);
    tbl_mux[tbl_len]   = mux;
    tbl_exc[tbl_len]   = exc;
    tbl_trap[tbl_len]  = trap;
    tbl_vec[tbl_len]   = vec;
    tbl_op[tbl_len]    = op;
    tbl_n[tbl_len]     = n;
    tbl_stall[tbl_len] = stall;
    tbl_kind[tbl_len]  = kind;
    tbl_addr[tbl_len]  = calc_start(mux, exc, trap, vec, op);
    tbl_len++;
  endtask

  // every address source gets its own offset from op
  task automatic drive_sources(input logic [31:0] op);
    logic [31:0] boot;
    boot = op + 32'h500;
    jump_id   <= op;
    jump_ex   <= op + 32'h100;
    mepc      <= op + 32'h200;
    depc      <= op + 32'h300;
    pc        <= op + 32'h400;
    boot_addr <= boot[31:1];
    m_base    <= op[31:8];
    mx_base   <= op[31:8] + 24'd1;
    u_base    <= op[31:8] + 24'd2;
  endtask

  // decode side, fixed stall pattern from the cycle count
  task automatic drive_decode(input logic [1:0] kind, input logic stall, input int unsigned n);
    logic rdy;
    logic hlt;
    rdy = 1'b1;
    hlt = 1'b0;
    if (kind != 2'd0) begin
      hlt = 1'b1;
    end else if (stall) begin
      rdy = (n % 3) != 0;
      hlt = (n % 5) == 2;
    end
    id_ready    <= rdy;
    halt_if     <= hlt;
    // failure rows keep clearing so the error bit reaches is_fetch_failed_o
    clear_valid <= (kind != 2'd0) | (rdy & ~hlt);
  endtask

  initial begin
    int unsigned limit;
    int unsigned waited;
    logic        done;
    void'($urandom(32'hb161));
    clk          = 1'b0;
    rst_n        = 1'b0;
    pc_mux       = PC_BOOT;
    exc_mux      = EXC_PC_EXCEPTION;
    trap_mux     = TRAP_MACHINE;
    exc_vec      = '0;
    drive_sources(32'h0);
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    instr_err    = 1'b0;
    gnt_wait     = 2'd0;
    withhold_gnt = 1'b0;
    req          = 1'b0;
    pc_set       = 1'b0;
    halt_if      = 1'b0;
    id_ready     = 1'b1;
    clear_valid  = 1'b0;
    row_start    = 1'b0;
    row_end      = 1'b0;
    row_fail     = 1'b0;
    row_timeout  = 1'b0;
    row_idx      = '0;
    row_addr     = '0;
    tbl_len      = 0;

    add_row(PC_BOOT,      EXC_PC_EXCEPTION, TRAP_MACHINE,  5'd0,  32'h0000_0b00, 8'd6, 1'b0, 2'd0);
    add_row(PC_JUMP,      EXC_PC_EXCEPTION, TRAP_MACHINE,  5'd0,  32'h0000_2000, 8'd4, 1'b0, 2'd0);
    add_row(PC_BRANCH,    EXC_PC_EXCEPTION, TRAP_MACHINE,  5'd0,  32'h0000_3000, 8'd4, 1'b0, 2'd0);
    add_row(PC_MRET,      EXC_PC_EXCEPTION, TRAP_MACHINE,  5'd0,  32'h0000_4000, 8'd3, 1'b1, 2'd0);
    add_row(PC_DRET,      EXC_PC_EXCEPTION, TRAP_MACHINE,  5'd0,  32'h0000_5000, 8'd3, 1'b0, 2'd0);
    add_row(PC_FENCEI,    EXC_PC_EXCEPTION, TRAP_MACHINE,  5'd0,  32'h0000_6000, 8'd3, 1'b0, 2'd0);
    add_row(PC_EXCEPTION, EXC_PC_EXCEPTION, TRAP_MACHINE,  5'd0,  32'h0000_7000, 8'd3, 1'b0, 2'd0);
    add_row(PC_EXCEPTION, EXC_PC_IRQ,       TRAP_USER,     5'd31, 32'h0000_8000, 8'd3, 1'b1, 2'd0);
    add_row(PC_EXCEPTION, EXC_PC_IRQ,       TRAP_MACHINEX, 5'd5,  32'h0000_9000, 8'd3, 1'b0, 2'd0);
    add_row(PC_EXCEPTION, EXC_PC_DBD,       TRAP_MACHINE,  5'd0,  32'h0000_0000, 8'd3, 1'b0, 2'd0);
    add_row(PC_JUMP,      EXC_PC_EXCEPTION, TRAP_MACHINE,  5'd0,  32'h0000_a000, 8'd8, 1'b1, 2'd0);
    add_row(PC_JUMP,      EXC_PC_EXCEPTION, TRAP_MACHINE,  5'd0,  32'h0000_f000, 8'd0, 1'b0, 2'd1);
    add_row(PC_BRANCH,    EXC_PC_EXCEPTION, TRAP_MACHINE,  5'd0,  32'h0000_b000, 8'd3, 1'b0, 2'd0);
    add_row(PC_JUMP,      EXC_PC_EXCEPTION, TRAP_MACHINE,  5'd0,  32'h0000_c000, 8'd0, 1'b0, 2'd2);

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    for (int r = 0; r < tbl_len; r++) begin
      // first row starts the stream with req_i, the others redirect
      pc_mux       <= tbl_mux[r];
      exc_mux      <= tbl_exc[r];
      trap_mux     <= tbl_trap[r];
      exc_vec      <= tbl_vec[r];
      drive_sources(tbl_op[r]);
      withhold_gnt <= (tbl_kind[r] == 2'd2);
      row_start    <= 1'b1;
      row_idx      <= 8'(r);
      row_addr     <= tbl_addr[r];
      row_fail     <= (tbl_kind[r] != 2'd0);
      row_timeout  <= 1'b0;
      id_ready     <= 1'b1;
      halt_if      <= (tbl_kind[r] != 2'd0);
      clear_valid  <= 1'b1;
      if (r == 0) begin
        req <= 1'b1;
      end else begin
        pc_set <= 1'b1;
      end
      @(posedge clk);
      pc_set    <= 1'b0;
      row_start <= 1'b0;

      limit  = WAIT_PER_WORD * ((tbl_n[r] == 8'd0) ? 1 : tbl_n[r]);
      waited = 0;
      done   = 1'b0;
      while (!done && waited < limit) begin
        drive_decode(tbl_kind[r], tbl_stall[r], waited);
        @(posedge clk);
        waited++;
        done = (tbl_kind[r] == 2'd0) ? (words_taken >= tbl_n[r]) : fail_seen;
      end

      row_timeout <= ~done;
      row_end     <= 1'b1;
      @(posedge clk);
      row_end <= 1'b0;
    end

    @(posedge clk);
    $display("rows run %0d, rows with errors %0d, words checked %0d",
             rows_run, rows_bad, words_checked);
    if (rows_bad == 0 && rows_run == tbl_len) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/fetch_fsm.sv
/*
  Fetch control. Offset FSM, decode handshake strobes towards the
  prefetch buffer, and the IF/ID registers that hold a word for decode.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_fsm
  import ibus_pkg::*;
(
  input  wire                clk,
  input  wire                rst_n,
  input  wire                req_i,
  input  wire                pc_set_i,
  input  wire                halt_if_i,
  input  wire                id_ready_i,
  input  wire                clear_instr_valid_i,
  input  wire                fetch_valid_i,
  input  wire [IBUS_DW-1:0]  fetch_rdata_i,
  input  wire                fetch_err_i,
  output logic               branch_req_o,
  output logic               fetch_ready_o,
  output logic               instr_valid_id_o,
  output logic [IBUS_DW-1:0] instr_rdata_id_o,
  output logic               is_fetch_failed_o,
  output logic               perf_imiss_o
);

  typedef enum logic {IDLE = 1'b0, WAIT = 1'b1} state_e;

  state_e state_q;
  state_e state_n;
  logic   offer;
  logic   transfer;
  // error bit of the word held in IF/ID
  logic   err_id_q;

  // -------------------------------------------------------------------------
  // offset FSM
  // -------------------------------------------------------------------------
  // first request after reset or any pc_set starts a new fetch stream
  assign branch_req_o = pc_set_i | ((state_q == IDLE) & req_i);
  // a redirect kills whatever sits at the buffer head
  assign offer        = (state_q == WAIT) & fetch_valid_i & ~pc_set_i;
  assign transfer     = offer & req_i & id_ready_i & ~halt_if_i;
  assign fetch_ready_o = transfer;

  always_comb begin
    state_n = state_q;
    if (branch_req_o) begin
      state_n = WAIT;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  // miss: nothing to hand over, or stream just restarted
  assign perf_imiss_o = ~fetch_valid_i | branch_req_o;

  // -------------------------------------------------------------------------
  // IF/ID pipeline registers, frozen while decode stalls
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o  <= 1'b0;
      instr_rdata_id_o  <= FETCH_RESET_WORD;
      is_fetch_failed_o <= 1'b0;
      err_id_q          <= 1'b0;
    end else if (transfer) begin
      instr_valid_id_o  <= 1'b1;
      instr_rdata_id_o  <= fetch_rdata_i;
      is_fetch_failed_o <= 1'b0;
      err_id_q          <= fetch_err_i;
    end else if (clear_instr_valid_i) begin
      instr_valid_id_o  <= 1'b0;
      // failure of the held word or of the one waiting behind it
      is_fetch_failed_o <= err_id_q | fetch_err_i;
    end
  end

  // a word at the buffer head stays until it is taken or flushed
  a_head_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    fetch_valid_i && !fetch_ready_o && !branch_req_o |=> fetch_valid_i)
    else $error("fetch_valid dropped without pop or flush");

endmodule

`default_nettype wire

// File: verilog/fetch_pkg.sv
/*
  Fetch address selection codes: sources of the next fetch address,
  exception targets and trap base select
*/
`default_nettype none

package fetch_pkg;

  // -------------------------------------------------------------------------
  // next fetch address source
  // -------------------------------------------------------------------------
  typedef enum logic [3:0] {
    PC_BOOT      = 4'b0000,
    PC_FENCEI    = 4'b0001,
    PC_JUMP      = 4'b0010,
    PC_BRANCH    = 4'b0011,
    PC_EXCEPTION = 4'b0100,
    PC_MRET      = 4'b0101,
    PC_DRET      = 4'b0111
  } pc_mux_e;

  // exception target inside the trap vector table
  typedef enum logic [2:0] {
    EXC_PC_EXCEPTION = 3'b000,
    EXC_PC_IRQ       = 3'b001,
    EXC_PC_DBD       = 3'b010
  } exc_pc_mux_e;

  // which trap base register is active
  typedef enum logic [1:0] {
    TRAP_MACHINE  = 2'b00,
    TRAP_USER     = 2'b01,
    TRAP_MACHINEX = 2'b10
  } trap_mux_e;

endpackage

`default_nettype wire

// File: verilog/fetch_watchdog.sv
/*
  Grant watchdog. Counts cycles a bus request waits for its grant and
  pulses a timeout flag once the limit is hit.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_watchdog #(
  parameter int unsigned GNT_TIMEOUT = 8
) (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  instr_req_i,
  input  wire  instr_gnt_i,
  input  wire  flush_i,
  output logic gnt_timeout_o
);

  localparam int unsigned CNT_W = $clog2(GNT_TIMEOUT + 1);

  logic [CNT_W-1:0] wait_cnt_q;
  logic             waiting;

  // request pending and not accepted this cycle
  assign waiting = instr_req_i & ~instr_gnt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt_q    <= '0;
      gnt_timeout_o <= 1'b0;
    end else begin
      gnt_timeout_o <= 1'b0;
      if (flush_i || !waiting) begin
        wait_cnt_q <= '0;
      end else if (wait_cnt_q == CNT_W'(GNT_TIMEOUT - 1)) begin
        // limit reached, single-cycle flag
        wait_cnt_q    <= '0;
        gnt_timeout_o <= 1'b1;
      end else begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end
    end
  end

  a_gnt_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n) instr_gnt_i |-> instr_req_i)
    else $error("instr_gnt_i without instr_req");

endmodule

`default_nettype wire

// File: verilog/ibus_pkg.sv
/*
  Instruction bus and fetch buffer constants
*/
`default_nettype none

package ibus_pkg;

  // address and data width of the instruction bus
  localparam int unsigned IBUS_AW = 32;
  localparam int unsigned IBUS_DW = 32;

  // one aligned word per fetch
  localparam logic [IBUS_AW-1:0] FETCH_ADDR_STEP = 32'd4;

  // addi x0, x0, 0
  localparam logic [IBUS_DW-1:0] FETCH_RESET_WORD = 32'h0000_0013;

endpackage

`default_nettype wire

// File: verilog/if_stage.sv
/*
  Instruction fetch stage top. Address select, prefetch buffer, grant
  watchdog and fetch FSM with the IF/ID registers.
*/
`timescale 1ns/1ps
`default_nettype none

module if_stage
  import fetch_pkg::*, ibus_pkg::*;
#(
  parameter logic [31:0] DM_HALT_ADDR = 32'h1a11_0800,
  parameter int unsigned FIFO_DEPTH   = 2,
  parameter int unsigned GNT_TIMEOUT  = 8
) (
  input  wire                clk,
  input  wire                rst_n,
  // address sources
  input  wire pc_mux_e       pc_mux_i,
  input  wire exc_pc_mux_e   exc_pc_mux_i,
  input  wire trap_mux_e     trap_addr_mux_i,
  input  wire [4:0]          exc_vec_pc_mux_i,
  input  wire [23:0]         m_trap_base_addr_i,
  input  wire [23:0]         m_trap_base_addrx_i,
  input  wire [23:0]         u_trap_base_addr_i,
  input  wire [IBUS_AW-2:0]  boot_addr_i,
  input  wire [IBUS_AW-1:0]  jump_target_id_i,
  input  wire [IBUS_AW-1:0]  jump_target_ex_i,
  input  wire [IBUS_AW-1:0]  mepc_i,
  input  wire [IBUS_AW-1:0]  depc_i,
  input  wire [IBUS_AW-1:0]  pc_i,
  // instruction bus
  output logic               instr_req_o,
  output logic [IBUS_AW-1:0] instr_addr_o,
  input  wire                instr_gnt_i,
  input  wire                instr_rvalid_i,
  input  wire [IBUS_DW-1:0]  instr_rdata_i,
  input  wire                instr_err_pmp_i,
  // control from decode / controller
  input  wire                req_i,
  input  wire                pc_set_i,
  input  wire                halt_if_i,
  input  wire                id_ready_i,
  input  wire                clear_instr_valid_i,
  // to decode
  output logic               instr_valid_id_o,
  output logic [IBUS_DW-1:0] instr_rdata_id_o,
  output logic               is_fetch_failed_o,
  output logic [IBUS_AW-1:0] branch_target_o,
  output logic               if_busy_o,
  output logic               perf_imiss_o
);

  logic               branch_req;
  logic               fetch_ready;
  logic               fetch_valid;
  logic [IBUS_DW-1:0] fetch_rdata;
  logic               fetch_err;
  logic               gnt_timeout;

  // selected address is also the branch target seen by decode
  pc_select #(.DM_HALT_ADDR(DM_HALT_ADDR)) i_pc_select (
    .pc_mux_i, .exc_pc_mux_i, .trap_addr_mux_i, .exc_vec_pc_mux_i,
    .m_trap_base_addr_i, .m_trap_base_addrx_i, .u_trap_base_addr_i,
    .boot_addr_i, .jump_target_id_i, .jump_target_ex_i,
    .mepc_i, .depc_i, .pc_i,
    .fetch_addr_o (branch_target_o)
  );

  prefetch_buffer #(.FIFO_DEPTH(FIFO_DEPTH)) i_prefetch_buffer (
    .clk, .rst_n, .req_i,
    .branch_i      (branch_req),
    .addr_i        (branch_target_o),
    .ready_i       (fetch_ready),
    .gnt_timeout_i (gnt_timeout),
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i,
    .instr_rdata_i, .instr_err_pmp_i,
    .valid_o       (fetch_valid),
    .rdata_o       (fetch_rdata),
    .err_o         (fetch_err),
    .busy_o        (if_busy_o)
  );

  fetch_watchdog #(.GNT_TIMEOUT(GNT_TIMEOUT)) i_fetch_watchdog (
    .clk, .rst_n,
    .instr_req_i   (instr_req_o),
    .instr_gnt_i,
    .flush_i       (branch_req),
    .gnt_timeout_o (gnt_timeout)
  );

  fetch_fsm i_fetch_fsm (
    .clk, .rst_n, .req_i, .pc_set_i, .halt_if_i, .id_ready_i, .clear_instr_valid_i,
    .fetch_valid_i (fetch_valid),
    .fetch_rdata_i (fetch_rdata),
    .fetch_err_i   (fetch_err),
    .branch_req_o  (branch_req),
    .fetch_ready_o (fetch_ready),
    .instr_valid_id_o, .instr_rdata_id_o, .is_fetch_failed_o, .perf_imiss_o
  );

endmodule

`default_nettype wire

// File: verilog/pc_select.sv
/*
  Next fetch address select. Picks the trap base, builds the exception
  or interrupt vector and muxes all address sources. Purely combinational.
*/
`timescale 1ns/1ps
`default_nettype none

module pc_select
  import fetch_pkg::*, ibus_pkg::*;
#(
  parameter logic [31:0] DM_HALT_ADDR = 32'h1a11_0800
) (
  input  wire pc_mux_e            pc_mux_i,
  input  wire exc_pc_mux_e        exc_pc_mux_i,
  input  wire trap_mux_e          trap_addr_mux_i,
  input  wire [4:0]               exc_vec_pc_mux_i,
  input  wire [23:0]              m_trap_base_addr_i,
  input  wire [23:0]              m_trap_base_addrx_i,
  input  wire [23:0]              u_trap_base_addr_i,
  input  wire [IBUS_AW-2:0]       boot_addr_i,
  input  wire [IBUS_AW-1:0]       jump_target_id_i,
  input  wire [IBUS_AW-1:0]       jump_target_ex_i,
  input  wire [IBUS_AW-1:0]       mepc_i,
  input  wire [IBUS_AW-1:0]       depc_i,
  input  wire [IBUS_AW-1:0]       pc_i,
  output logic [IBUS_AW-1:0]      fetch_addr_o
);

  logic [23:0]        trap_base;
  logic [IBUS_AW-1:0] exc_pc;
  logic [IBUS_AW-1:0] addr_sel;

  // trap base, then exception / irq / debug target
  always_comb begin
    trap_base = m_trap_base_addr_i;
    unique case (trap_addr_mux_i)
      TRAP_USER:     trap_base = u_trap_base_addr_i;
      TRAP_MACHINEX: trap_base = m_trap_base_addrx_i;
      default:       trap_base = m_trap_base_addr_i;
    endcase

    exc_pc = '0;
    unique case (exc_pc_mux_i)
      EXC_PC_EXCEPTION: exc_pc = {trap_base, 8'h00};
      // vectored: one 4-byte slot per line
      EXC_PC_IRQ:       exc_pc = {trap_base, 1'b0, exc_vec_pc_mux_i, 2'b00};
      EXC_PC_DBD:       exc_pc = DM_HALT_ADDR;
      default:          exc_pc = '0;
    endcase
  end

  // address source mux
  always_comb begin
    addr_sel = '0;
    unique case (pc_mux_i)
      PC_BOOT:      addr_sel = {boot_addr_i, 1'b0};
      PC_JUMP:      addr_sel = jump_target_id_i;
      PC_BRANCH:    addr_sel = jump_target_ex_i;
      PC_EXCEPTION: addr_sel = exc_pc;
      PC_MRET:      addr_sel = mepc_i;
      PC_DRET:      addr_sel = depc_i;
      // refetch the word after the fence
      PC_FENCEI:    addr_sel = pc_i + FETCH_ADDR_STEP;
      default:      addr_sel = '0;
    endcase
  end

  assign fetch_addr_o = {addr_sel[IBUS_AW-1:1], 1'b0};

endmodule

`default_nettype wire

// File: verilog/prefetch_buffer.sv
/*
  Prefetch buffer. Issues word requests on the instruction bus while
  there is room and keeps fetched words with their error bits in a FIFO.
*/
`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer
  import ibus_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                req_i,
  input  wire                branch_i,
  input  wire [IBUS_AW-1:0]  addr_i,
  input  wire                ready_i,
  input  wire                gnt_timeout_i,
  output logic               instr_req_o,
  output logic [IBUS_AW-1:0] instr_addr_o,
  input  wire                instr_gnt_i,
  input  wire                instr_rvalid_i,
  input  wire [IBUS_DW-1:0]  instr_rdata_i,
  input  wire                instr_err_pmp_i,
  output logic               valid_o,
  output logic [IBUS_DW-1:0] rdata_o,
  output logic               err_o,
  output logic               busy_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [IBUS_DW-1:0] data_mem [FIFO_DEPTH];
  logic               err_mem  [FIFO_DEPTH];
  logic [PTR_W-1:0]   wptr_q, rptr_q;
  // stored words, granted-but-unanswered requests, stale answers to drop
  logic [CNT_W-1:0]   cnt_q, out_q, disc_q;
  logic [IBUS_AW-1:0] addr_q;
  logic               active_q, tmo_pend_q;
  logic               room, gnt, push_rsp, push_tmo, push, pop;

  // -------------------------------------------------------------------------
  // request side
  // -------------------------------------------------------------------------
  assign room = ({1'b0, cnt_q} + {1'b0, out_q}) < (CNT_W + 1)'(FIFO_DEPTH);
  assign instr_req_o  = active_q & req_i & room & ~branch_i & ~gnt_timeout_i & ~tmo_pend_q;
  assign instr_addr_o = addr_q;
  assign gnt          = instr_req_o & instr_gnt_i;

  // -------------------------------------------------------------------------
  // FIFO side
  // -------------------------------------------------------------------------
  assign push_rsp = instr_rvalid_i & (disc_q == '0);
  // error entry waits until all earlier answers are in, keeps order
  assign push_tmo = tmo_pend_q & (out_q == '0);
  assign push     = push_rsp | push_tmo;
  assign valid_o  = (cnt_q != '0);
  assign pop      = ready_i & valid_o;
  assign rdata_o  = data_mem[rptr_q];
  assign err_o    = valid_o & err_mem[rptr_q];
  assign busy_o   = valid_o | (out_q != '0);

  always_ff @(posedge clk) begin
    if (push && !branch_i) begin
      data_mem[wptr_q] <= push_tmo ? FETCH_RESET_WORD : instr_rdata_i;
      err_mem[wptr_q]  <= push_tmo | instr_err_pmp_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr_q     <= '0;
      rptr_q     <= '0;
      cnt_q      <= '0;
      out_q      <= '0;
      disc_q     <= '0;
      addr_q     <= '0;
      active_q   <= 1'b0;
      tmo_pend_q <= 1'b0;
    end else begin
      out_q <= out_q + CNT_W'(gnt) - CNT_W'(instr_rvalid_i);
      if (branch_i) begin
        // flush, everything still in flight is stale
        wptr_q     <= '0;
        rptr_q     <= '0;
        cnt_q      <= '0;
        disc_q     <= out_q - CNT_W'(instr_rvalid_i);
        addr_q     <= addr_i;
        active_q   <= 1'b1;
        tmo_pend_q <= 1'b0;
      end else begin
        if (push) wptr_q <= wptr_q + 1'b1;
        if (pop)  rptr_q <= rptr_q + 1'b1;
        cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
        if (instr_rvalid_i && disc_q != '0) disc_q <= disc_q - 1'b1;
        // timed-out word counts as fetched, move on
        if (gnt || gnt_timeout_i) addr_q <= addr_q + FETCH_ADDR_STEP;
        if (gnt_timeout_i) begin
          tmo_pend_q <= 1'b1;
        end else if (push_tmo) begin
          tmo_pend_q <= 1'b0;
        end
      end
    end
  end

  a_rvalid_outstanding: assert property (
    @(posedge clk) disable iff (!rst_n) instr_rvalid_i |-> (out_q != '0))
    else $error("instr_rvalid_i with no request outstanding");

endmodule

`default_nettype wire
